// File: src/axis_out_pkg.sv
package axis_out_pkg;

   // width of one register word
   localparam int WORD_W = 32;

   // register bus address width
   localparam int ADDR_W = 3;

   // default fifo depth is 2**FIFO_ADDR_W_DEF
   localparam int FIFO_ADDR_W_DEF = 4;

   // register map, one word per offset
   localparam logic [ADDR_W-1:0] REG_SOFT_RESET = 3'd0;
   localparam logic [ADDR_W-1:0] REG_ENABLE     = 3'd1;
   localparam logic [ADDR_W-1:0] REG_DATA       = 3'd2;
   localparam logic [ADDR_W-1:0] REG_NWORDS     = 3'd3;
   localparam logic [ADDR_W-1:0] REG_THRESHOLD  = 3'd4;
   localparam logic [ADDR_W-1:0] REG_STATUS     = 3'd5;
   localparam logic [ADDR_W-1:0] REG_LEVEL      = 3'd6;

   // software configuration, system clock domain
   typedef struct packed {
      logic              soft_reset;
      logic              enable;
      logic [WORD_W-1:0] nwords;
      logic [WORD_W-1:0] threshold;
   } axis_cfg_t;

   // write side fifo status
   // level is zero-extended to a full word so the struct
   // does not depend on the fifo depth
   typedef struct packed {
      logic              empty;
      logic              full;
      logic [WORD_W-1:0] level;
   } fifo_status_t;

endpackage

// File: src/axis_out_sync.sv
`timescale 1ns/1ps

module axis_out_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic [WIDTH-1:0] signal_i,
   output logic [WIDTH-1:0] signal_o
);

   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   // two flop chain into clk_i
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   assign signal_o = sync_q;

endmodule

// File: src/axis_out_csr.sv
`timescale 1ns/1ps

module axis_out_csr import axis_out_pkg::*; #(
   parameter int DATA_W = WORD_W
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                iob_valid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_ready_o,
   output logic                iob_rvalid_o,
   output logic [DATA_W-1:0]   iob_rdata_o,
   input  logic                dma_tvalid_i,
   input  logic [DATA_W-1:0]   dma_tdata_i,
   output logic                dma_tready_o,
   input  fifo_status_t        status_i,
   output axis_cfg_t           cfg_o,
   output logic                fifo_wen_o,
   output logic [DATA_W-1:0]   fifo_wdata_o,
   output logic                interrupt_o
);

   axis_cfg_t         cfg_q;
   logic              is_write;
   logic              data_req;
   logic              xfer;
   logic              cpu_push;
   logic              rvalid_q;
   logic              irq_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] rdata_nxt;

   assign is_write = |iob_wstrb_i;
   assign data_req = iob_valid_i & is_write & (iob_addr_i == REG_DATA);

   // stall a cpu data write while full or while the dma owns the fifo port
   assign iob_ready_o = ~(data_req & (status_i.full | dma_tvalid_i));
   assign xfer        = iob_valid_i & iob_ready_o;
   assign cpu_push    = data_req & iob_ready_o;

   // dma wins over cpu in the same cycle
   assign dma_tready_o = ~status_i.full;
   assign fifo_wen_o   = (dma_tvalid_i | cpu_push) & ~status_i.full;
   assign fifo_wdata_o = dma_tvalid_i ? dma_tdata_i : iob_wdata_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_q <= '0;
      end else if (xfer && is_write) begin
         case (iob_addr_i)
            REG_SOFT_RESET: cfg_q.soft_reset <= iob_wdata_i[0];
            REG_ENABLE:     cfg_q.enable     <= iob_wdata_i[0];
            REG_NWORDS:     cfg_q.nwords     <= WORD_W'(iob_wdata_i);
            REG_THRESHOLD:  cfg_q.threshold  <= WORD_W'(iob_wdata_i);
            default: ;
         endcase
      end
   end

   // read-back mux
   always_comb begin
      rdata_nxt = '0;
      case (iob_addr_i)
         REG_SOFT_RESET: rdata_nxt[0]   = cfg_q.soft_reset;
         REG_ENABLE:     rdata_nxt[0]   = cfg_q.enable;
         REG_NWORDS:     rdata_nxt      = DATA_W'(cfg_q.nwords);
         REG_THRESHOLD:  rdata_nxt      = DATA_W'(cfg_q.threshold);
         REG_STATUS:     rdata_nxt[1:0] = {status_i.full, status_i.empty};
         REG_LEVEL:      rdata_nxt      = DATA_W'(status_i.level);
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
         irq_q    <= 1'b0;
      end else begin
         rvalid_q <= xfer & ~is_write;
         irq_q    <= status_i.level <= cfg_q.threshold;
      end
   end

   always_ff @(posedge clk_i) begin
      if (xfer && !is_write) begin
         rdata_q <= rdata_nxt;
      end
   end

   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o  = rdata_q;
   assign cfg_o        = cfg_q;
   assign interrupt_o  = irq_q;

endmodule

// File: src/axis_out_async_fifo.sv
`timescale 1ns/1ps

module axis_out_async_fifo import axis_out_pkg::*; #(
   parameter int DATA_W      = WORD_W,
   parameter int FIFO_ADDR_W = FIFO_ADDR_W_DEF
) (
   // write side, system clock
   input  logic              w_clk_i,
   input  logic              w_arst_n_i,
   input  logic              w_rst_i,
   input  logic              w_en_i,
   input  logic [DATA_W-1:0] w_data_i,
   output fifo_status_t      w_status_o,
   // read side, stream clock
   input  logic              r_clk_i,
   input  logic              r_arst_n_i,
   input  logic              r_rst_i,
   input  logic              r_en_i,
   output logic [DATA_W-1:0] r_data_o,
   output logic              r_empty_o
);

   localparam int PTR_W = FIFO_ADDR_W + 1;
   // top two gray bits differ when the pointers are one lap apart
   localparam logic [PTR_W-1:0] FULL_MASK = 2'b11 << (FIFO_ADDR_W - 1);

   logic [DATA_W-1:0] mem [2**FIFO_ADDR_W];

   logic [PTR_W-1:0]  w_bin_q;
   logic [PTR_W-1:0]  w_gray_q;
   logic [PTR_W-1:0]  w_bin_nxt;
   logic [PTR_W-1:0]  r_gray_w;
   logic [PTR_W-1:0]  r_bin_w;
   logic [PTR_W-1:0]  w_level;
   logic              w_full;
   logic              w_push;

   logic [PTR_W-1:0]  r_bin_q;
   logic [PTR_W-1:0]  r_gray_q;
   logic [PTR_W-1:0]  r_bin_nxt;
   logic [PTR_W-1:0]  w_gray_r;
   logic              r_empty;
   logic              r_pop;
   logic [DATA_W-1:0] r_data_q;

   function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // write pointer
   assign w_full    = (w_gray_q == (r_gray_w ^ FULL_MASK));
   assign w_push    = w_en_i & ~w_full;
   assign w_bin_nxt = w_bin_q + 1'b1;

   always_ff @(posedge w_clk_i or negedge w_arst_n_i) begin
      if (!w_arst_n_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_rst_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_push) begin
         w_bin_q  <= w_bin_nxt;
         w_gray_q <= bin2gray(w_bin_nxt);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin_q[FIFO_ADDR_W-1:0]] <= w_data_i;
      end
   end

   // write side status against the synchronized read pointer
   assign r_bin_w = gray2bin(r_gray_w);
   assign w_level = w_bin_q - r_bin_w;

   assign w_status_o.empty = (w_gray_q == r_gray_w);
   assign w_status_o.full  = w_full;
   assign w_status_o.level = WORD_W'(w_level);

   // read pointer
   assign r_empty   = (r_gray_q == w_gray_r);
   assign r_pop     = r_en_i & ~r_empty;
   assign r_bin_nxt = r_bin_q + 1'b1;

   always_ff @(posedge r_clk_i or negedge r_arst_n_i) begin
      if (!r_arst_n_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_rst_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_pop) begin
         r_bin_q  <= r_bin_nxt;
         r_gray_q <= bin2gray(r_bin_nxt);
      end
   end

   // registered read, holds until the next pop
   always_ff @(posedge r_clk_i) begin
      if (r_pop) begin
         r_data_q <= mem[r_bin_q[FIFO_ADDR_W-1:0]];
      end
   end

   assign r_data_o  = r_data_q;
   assign r_empty_o = r_empty;

   axis_out_sync #(
      .WIDTH(PTR_W)
   ) sync_r2w (
      .clk_i   (w_clk_i),
      .arst_n_i(w_arst_n_i),
      .signal_i(r_gray_q),
      .signal_o(r_gray_w)
   );

   axis_out_sync #(
      .WIDTH(PTR_W)
   ) sync_w2r (
      .clk_i   (r_clk_i),
      .arst_n_i(r_arst_n_i),
      .signal_i(w_gray_q),
      .signal_o(w_gray_r)
   );

endmodule

// File: src/axis_out_tx.sv
`timescale 1ns/1ps

module axis_out_tx import axis_out_pkg::*; #(
   parameter int DATA_W = WORD_W
) (
   input  logic              axis_clk_i,
   input  logic              axis_arst_n_i,
   input  logic              sw_rst_i,
   input  logic              enable_i,
   input  logic [WORD_W-1:0] nwords_i,
   input  logic              fifo_empty_i,
   input  logic [DATA_W-1:0] fifo_rdata_i,
   output logic              fifo_ren_o,
   output logic              axis_tvalid_o,
   output logic [DATA_W-1:0] axis_tdata_o,
   output logic              axis_tlast_o,
   input  logic              axis_tready_i
);

   // streaming_q doubles as the registered tvalid
   logic              streaming_q;
   logic              streaming_nxt;
   logic              rd_req;
   logic [WORD_W-1:0] beat_cnt_q;

   always_comb begin
      streaming_nxt = streaming_q;
      rd_req        = 1'b0;
      if (!streaming_q) begin
         if (!fifo_empty_i) begin
            rd_req        = 1'b1;
            streaming_nxt = 1'b1;
         end
      end else if (axis_tready_i) begin
         // beat taken, fetch the next one or go idle
         if (fifo_empty_i) begin
            streaming_nxt = 1'b0;
         end else begin
            rd_req = 1'b1;
         end
      end
   end

   assign fifo_ren_o = rd_req & enable_i & ~sw_rst_i;

   always_ff @(posedge axis_clk_i or negedge axis_arst_n_i) begin
      if (!axis_arst_n_i) begin
         streaming_q <= 1'b0;
         beat_cnt_q  <= '0;
      end else if (sw_rst_i) begin
         streaming_q <= 1'b0;
         beat_cnt_q  <= '0;
      end else if (enable_i) begin
         streaming_q <= streaming_nxt;
         if (rd_req) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   // fifo read data is already registered and held until the next read
   assign axis_tdata_o  = fifo_rdata_i;
   assign axis_tvalid_o = streaming_q;
   assign axis_tlast_o  = streaming_q & (beat_cnt_q == nwords_i);

endmodule

// File: src/axis_out.sv
`timescale 1ns/1ps

module axis_out import axis_out_pkg::*; #(
   parameter int DATA_W      = WORD_W,
   parameter int FIFO_ADDR_W = FIFO_ADDR_W_DEF
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                iob_valid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_ready_o,
   output logic                iob_rvalid_o,
   output logic [DATA_W-1:0]   iob_rdata_o,
   input  logic                dma_tvalid_i,
   input  logic [DATA_W-1:0]   dma_tdata_i,
   output logic                dma_tready_o,
   output logic                interrupt_o,
   input  logic                axis_clk_i,
   input  logic                axis_arst_n_i,
   output logic                axis_tvalid_o,
   input  logic                axis_tready_i,
   output logic [DATA_W-1:0]   axis_tdata_o,
   output logic                axis_tlast_o
);

   axis_cfg_t         cfg;
   fifo_status_t      fifo_status;
   logic              fifo_wen;
   logic [DATA_W-1:0] fifo_wdata;
   logic              fifo_ren;
   logic              fifo_empty;
   logic [DATA_W-1:0] fifo_rdata;

   // configuration in the stream domain
   logic              axis_sw_rst;
   logic              axis_enable;
   logic [WORD_W-1:0] axis_nwords;

   axis_out_csr #(
      .DATA_W(DATA_W)
   ) csr0 (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .iob_valid_i (iob_valid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_ready_o (iob_ready_o),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .dma_tvalid_i(dma_tvalid_i),
      .dma_tdata_i (dma_tdata_i),
      .dma_tready_o(dma_tready_o),
      .status_i    (fifo_status),
      .cfg_o       (cfg),
      .fifo_wen_o  (fifo_wen),
      .fifo_wdata_o(fifo_wdata),
      .interrupt_o (interrupt_o)
   );

   axis_out_sync #(
      .WIDTH(1)
   ) sync_sw_rst (
      .clk_i   (axis_clk_i),
      .arst_n_i(axis_arst_n_i),
      .signal_i(cfg.soft_reset),
      .signal_o(axis_sw_rst)
   );

   axis_out_sync #(
      .WIDTH(1)
   ) sync_enable (
      .clk_i   (axis_clk_i),
      .arst_n_i(axis_arst_n_i),
      .signal_i(cfg.enable),
      .signal_o(axis_enable)
   );

   axis_out_sync #(
      .WIDTH(WORD_W)
   ) sync_nwords (
      .clk_i   (axis_clk_i),
      .arst_n_i(axis_arst_n_i),
      .signal_i(cfg.nwords),
      .signal_o(axis_nwords)
   );

   axis_out_async_fifo #(
      .DATA_W     (DATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) fifo0 (
      .w_clk_i   (clk_i),
      .w_arst_n_i(arst_n_i),
      .w_rst_i   (cfg.soft_reset),
      .w_en_i    (fifo_wen),
      .w_data_i  (fifo_wdata),
      .w_status_o(fifo_status),
      .r_clk_i   (axis_clk_i),
      .r_arst_n_i(axis_arst_n_i),
      .r_rst_i   (axis_sw_rst),
      .r_en_i    (fifo_ren),
      .r_data_o  (fifo_rdata),
      .r_empty_o (fifo_empty)
   );

   axis_out_tx #(
      .DATA_W(DATA_W)
   ) tx0 (
      .axis_clk_i   (axis_clk_i),
      .axis_arst_n_i(axis_arst_n_i),
      .sw_rst_i     (axis_sw_rst),
      .enable_i     (axis_enable),
      .nwords_i     (axis_nwords),
      .fifo_empty_i (fifo_empty),
      .fifo_rdata_i (fifo_rdata),
      .fifo_ren_o   (fifo_ren),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

// File: tb/axis_out_sva.sv
`timescale 1ns/1ps

module axis_out_sva import axis_out_pkg::*; #(
   parameter int DATA_W = WORD_W
) (
   input logic                clk_i,
   input logic                arst_n_i,
   input logic                axis_clk_i,
   input logic                axis_arst_n_i,
   input logic                iob_valid_i,
   input logic                iob_ready_o,
   input logic [DATA_W/8-1:0] iob_wstrb_i,
   input logic                iob_rvalid_o,
   input logic                axis_tvalid_o,
   input logic                axis_tready_i,
   input logic [DATA_W-1:0]   axis_tdata_o,
   input logic                axis_tlast_o
);

   // stalled beat holds its payload
   beat_held: assert property (@(posedge axis_clk_i) disable iff (!axis_arst_n_i)
      axis_tvalid_o && !axis_tready_i |=>
         axis_tvalid_o && $stable(axis_tdata_o) && $stable(axis_tlast_o))
      else $error("stream beat changed while stalled");

   // read data one cycle after an accepted read
   read_returns: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iob_valid_i && iob_ready_o && !(|iob_wstrb_i) |=> iob_rvalid_o)
      else $error("read accepted without rvalid");

   rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iob_rvalid_o |-> $past(iob_valid_i && iob_ready_o && !(|iob_wstrb_i)))
      else $error("rvalid without a read");

endmodule

bind axis_out axis_out_sva #(
   .DATA_W(DATA_W)
) sva0 (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .axis_clk_i   (axis_clk_i),
   .axis_arst_n_i(axis_arst_n_i),
   .iob_valid_i  (iob_valid_i),
   .iob_ready_o  (iob_ready_o),
   .iob_wstrb_i  (iob_wstrb_i),
   .iob_rvalid_o (iob_rvalid_o),
   .axis_tvalid_o(axis_tvalid_o),
   .axis_tready_i(axis_tready_i),
   .axis_tdata_o (axis_tdata_o),
   .axis_tlast_o (axis_tlast_o)
);

// File: tb/axis_out_tb.sv
`timescale 1ns/1ps

module axis_out_tb import axis_out_pkg::*;;

   localparam int DATA_W  = 32;
   localparam int DEPTH   = 2 ** FIFO_ADDR_W_DEF;
   localparam int TIMEOUT = 2000;

   logic              clk_i = 1'b0;
   logic              axis_clk_i = 1'b0;
   logic              arst_n_i;
   logic              axis_arst_n_i;
   logic              iob_valid_i;
   logic [ADDR_W-1:0] iob_addr_i;
   logic [DATA_W-1:0] iob_wdata_i;
   logic [3:0]        iob_wstrb_i;
   logic              iob_ready_o;
   logic              iob_rvalid_o;
   logic [DATA_W-1:0] iob_rdata_o;
   logic              dma_tvalid_i;
   logic [DATA_W-1:0] dma_tdata_i;
   logic              dma_tready_o;
   logic              interrupt_o;
   logic              axis_tvalid_o;
   logic              axis_tready_i;
   logic [DATA_W-1:0] axis_tdata_o;
   logic              axis_tlast_o;

   integer            seed = 32'h4a2b_a2e7;
   logic [DATA_W-1:0] exp_q[$];
   int                beat_idx = 0;
   int                nwords_exp = 0;
   int                threshold_exp = 0;
   int                error_cnt = 0;
   bit                backpressure = 1'b0;
   bit                run_done = 1'b0;
   logic              bus_acc = 1'b0;
   logic              dma_acc = 1'b0;
   logic [DATA_W-1:0] rd_val;

   always #5 clk_i = ~clk_i;
   always #7 axis_clk_i = ~axis_clk_i;

   axis_out dut0 (.*);

   // handshakes seen at each rising edge
   always @(posedge clk_i) begin
      bus_acc <= iob_valid_i & iob_ready_o;
      dma_acc <= dma_tvalid_i & dma_tready_o;
   end

   task automatic stop_on_error(input string msg);
      error_cnt++;
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic expect_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      assert (exp === act) else
         stop_on_error($sformatf("ERROR: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [3:0] strb);
      int n;
      @(negedge clk_i);
      iob_valid_i = 1'b1;
      iob_addr_i  = addr;
      iob_wdata_i = data;
      iob_wstrb_i = strb;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) stop_on_error("register bus access was never accepted");
      end while (!bus_acc);
      iob_valid_i = 1'b0;
      iob_wstrb_i = '0;
      if (strb != 0 && addr == REG_DATA) exp_q.push_back(data);
   endtask

   task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      bus_access(addr, data, 4'hf);
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      int n;
      bus_access(addr, '0, 4'h0);
      n = 0;
      while (!iob_rvalid_o) begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) stop_on_error("read data never returned");
      end
      data = iob_rdata_o;
   endtask

   task automatic dma_push(input logic [DATA_W-1:0] data);
      int n;
      @(negedge clk_i);
      dma_tvalid_i = 1'b1;
      dma_tdata_i  = data;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) stop_on_error("dma word was never accepted");
      end while (!dma_acc);
      dma_tvalid_i = 1'b0;
      exp_q.push_back(data);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0 || axis_tvalid_o) begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) stop_on_error("stream did not deliver all expected words");
      end
   endtask

   // pulse soft reset, hold it long enough to reach the stream side
   task automatic soft_reset_pulse();
      reg_write(REG_SOFT_RESET, 1);
      exp_q.delete();
      beat_idx = 0;
      repeat (10) @(negedge clk_i);
      reg_read(REG_STATUS, rd_val);
      expect_value("REG_STATUS", 32'h1, rd_val);
      reg_write(REG_SOFT_RESET, 0);
   endtask

   // random back-pressure on the sink
   always @(negedge axis_clk_i) begin
      axis_tready_i <= backpressure ? (($random(seed) & 3) != 0) : 1'b1;
   end

   // scoreboard on every accepted beat
   always @(posedge axis_clk_i) begin
      if (axis_arst_n_i && axis_tvalid_o && axis_tready_i) begin
         if (exp_q.size() == 0) begin
            stop_on_error("stream beat arrived with no word expected");
         end else begin
            beat_idx++;
            assert (axis_tdata_o == exp_q[0]) else
               stop_on_error($sformatf("ERROR: axis_tdata_o expected %h actual %h",
                                       exp_q[0], axis_tdata_o));
            assert (axis_tlast_o == (beat_idx == nwords_exp)) else
               stop_on_error($sformatf("ERROR: axis_tlast_o expected %h actual %h",
                                       beat_idx == nwords_exp, axis_tlast_o));
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin
      arst_n_i = 1'b0;
      axis_arst_n_i = 1'b0;
      iob_valid_i = 1'b0;
      iob_addr_i = '0;
      iob_wdata_i = '0;
      iob_wstrb_i = '0;
      dma_tvalid_i = 1'b0;
      dma_tdata_i = '0;
      axis_tready_i = 1'b1;
      repeat (8) @(negedge clk_i);
      arst_n_i = 1'b1;
      axis_arst_n_i = 1'b1;

      nwords_exp = 6;
      threshold_exp = 3;
      reg_write(REG_NWORDS, nwords_exp);
      reg_write(REG_THRESHOLD, threshold_exp);
      reg_write(REG_ENABLE, 1);
      backpressure = 1'b1;

      // cpu words, then dma words, then both at once
      repeat (3) reg_write(REG_DATA, $random(seed));
      repeat (2) dma_push($random(seed));
      fork
         dma_push($random(seed));
         reg_write(REG_DATA, $random(seed));
      join
      wait_drained();

      // fill with the stream side stopped
      reg_write(REG_ENABLE, 0);
      repeat (4) @(negedge clk_i);
      for (int k = 1; k <= DEPTH; k++) begin
         reg_write(REG_DATA, $random(seed));
         @(negedge clk_i);
         expect_value("interrupt_o", k <= threshold_exp, interrupt_o);
      end
      expect_value("dma_tready_o", 0, dma_tready_o);
      reg_read(REG_STATUS, rd_val);
      expect_value("REG_STATUS", 32'h2, rd_val);
      reg_read(REG_LEVEL, rd_val);
      expect_value("REG_LEVEL", DEPTH, rd_val);

      // soft reset empties the fifo and restarts the beat count
      soft_reset_pulse();
      nwords_exp = 3;
      reg_write(REG_NWORDS, nwords_exp);
      reg_write(REG_ENABLE, 1);
      repeat (3) reg_write(REG_DATA, $random(seed));
      repeat (2) dma_push($random(seed));
      wait_drained();

      run_done = 1'b1;
      if (error_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // run stopped early by a failing bound assertion
   final begin
      if (!run_done && error_cnt == 0) $display("ERRORS FOUND");
   end

endmodule

// File: filelist.f
src/axis_out_pkg.sv
src/axis_out_sync.sv
src/axis_out_csr.sv
src/axis_out_async_fifo.sv
src/axis_out_tx.sv
src/axis_out.sv
tb/axis_out_sva.sv
tb/axis_out_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, decide by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module axis_out_tb \
   -f filelist.f -o axis_out_sim \
   && ./obj_dir/axis_out_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
